// ==== elevator_dispatch.f ====
+incdir+hdl
hdl/elevator_pkg.sv
hdl/request_registers.sv
hdl/target_selector.sv
hdl/car_fsm.sv
hdl/car_position.sv
hdl/elevator_top.sv
tests/tb_elevator.sv

// ==== hdl/car_fsm.sv ====
////////////////////
// Car FSM
// Dispatch on target, stop on arrival, power switch park,
// emergency dispatch block, door lights
////////////////////

`timescale 1ns/1ps

module car_fsm import elevator_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       power_switch,
    input  logic       emergency_btn,
    input  logic       door_open_btn,
    input  logic       door_close_btn,
    input  logic       have_target,
    input  floor_t     target_floor,
    input  direction_t target_direction,
    input  floor_t     current_floor,
    input  logic       floor_arrive,
    output car_state_t car_state,
    output direction_t car_direction,
    output logic       flush_requests,
    output logic       door_open_light,
    output logic       door_close_light
);

    floor_t target_latch;
    logic   power_prev;
    logic   dispatch;

    // Leave a stop only with the switch low and no emergency
    assign dispatch = (car_state == CAR_STOPPED) && have_target &&
                      !emergency_btn && !power_switch;

    // Turning the switch on drops every pending request
    assign flush_requests = power_switch && !power_prev;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car_state     <= CAR_STOPPED;
            car_direction <= DIR_UP;
            power_prev    <= 1'b0;
        end else begin
            power_prev <= power_switch;
            case (car_state)
                CAR_STOPPED: begin
                    if (power_switch) begin
                        car_state <= CAR_PARKED;
                    end else if (dispatch) begin
                        car_state     <= (target_direction == DIR_UP) ?
                                         CAR_MOVING_UP : CAR_MOVING_DOWN;
                        car_direction <= target_direction;
                    end
                end
                CAR_MOVING_UP, CAR_MOVING_DOWN: begin
                    // Switch on during travel parks at the next floor reached
                    if (floor_arrive && power_switch) begin
                        car_state <= CAR_PARKED;
                    end else if (floor_arrive && (current_floor == target_latch)) begin
                        car_state <= CAR_STOPPED;
                    end
                end
                CAR_PARKED: begin
                    if (!power_switch) begin
                        car_state <= CAR_STOPPED;
                    end
                end
                default: car_state <= CAR_STOPPED;
            endcase
        end
    end

    // Target held for the whole trip
    always_ff @(posedge clock) begin
        if (dispatch) begin
            target_latch <= target_floor;
        end
    end

    // Doors are only operable at a normal stop
    assign door_open_light  = (car_state == CAR_STOPPED) && !emergency_btn &&
                              !power_switch && door_open_btn;
    assign door_close_light = (car_state == CAR_STOPPED) && !emergency_btn &&
                              !power_switch && door_close_btn;

endmodule

// ==== hdl/car_position.sv ====
////////////////////
// Car position
// Travel timer and floor counter
////////////////////

`timescale 1ns/1ps

`include "elevator_consts.svh"

module car_position import elevator_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  car_state_t car_state,
    output floor_t     current_floor,
    output logic       floor_arrive
);

    logic [`ELEV_TIMER_W-1:0] travel_count;
    logic                     leg_done;

    // Last cycle of a one floor leg
    assign leg_done = (travel_count == `ELEV_TIMER_W'(`ELEV_TRAVEL_CYCLES - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            travel_count  <= '0;
            current_floor <= '0;
            floor_arrive  <= 1'b0;
        end else if ((car_state == CAR_MOVING_UP) || (car_state == CAR_MOVING_DOWN)) begin
            if (leg_done) begin
                travel_count <= '0;
                floor_arrive <= 1'b1;
                // Shaft ends hold the count
                if ((car_state == CAR_MOVING_UP) &&
                    (current_floor != floor_t'(`ELEV_TOP_FLOOR))) begin
                    current_floor <= current_floor + 1'b1;
                end else if ((car_state == CAR_MOVING_DOWN) && (current_floor != '0)) begin
                    current_floor <= current_floor - 1'b1;
                end
            end else begin
                travel_count <= travel_count + 1'b1;
                floor_arrive <= 1'b0;
            end
        end else begin
            travel_count <= '0;
            floor_arrive <= 1'b0;
        end
    end

endmodule

// ==== hdl/elevator_consts.svh ====
////////////////////
// Elevator constants
// Floor count, floor and timer widths,
// travel time per floor
////////////////////

`ifndef ELEVATOR_CONSTS_SVH
`define ELEVATOR_CONSTS_SVH

// Building size with floor 0 as the lowest
`define ELEV_NUM_FLOORS 11
`define ELEV_FLOOR_W 4
`define ELEV_TOP_FLOOR 10

// Clock cycles the car needs between two adjacent floors
`define ELEV_TRAVEL_CYCLES 8
`define ELEV_TIMER_W 4

`endif

// ==== hdl/elevator_pkg.sv ====
////////////////////
// Elevator types
// Floor index, floor mask, car state and direction enums
////////////////////

`include "elevator_consts.svh"

package elevator_pkg;

    typedef logic [`ELEV_FLOOR_W-1:0] floor_t;

    // Bit i stands for floor i
    typedef logic [`ELEV_NUM_FLOORS-1:0] floor_mask_t;

    typedef enum logic [1:0] {
        CAR_STOPPED     = 2'd0,
        CAR_MOVING_UP   = 2'd1,
        CAR_MOVING_DOWN = 2'd2,
        CAR_PARKED      = 2'd3
    } car_state_t;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

// ==== hdl/elevator_top.sv ====
////////////////////
// Elevator controller top level
// Request store, target selector,
// car FSM and car position
////////////////////

`timescale 1ns/1ps

module elevator_top import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    output floor_t      current_floor,
    output car_state_t  car_state,
    output direction_t  car_direction,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output logic        door_open_light,
    output logic        door_close_light
);

    // Pending requests toward the selector
    floor_mask_t up_requests;
    floor_mask_t down_requests;
    floor_mask_t panel_requests;

    // Selector result
    logic        have_target;
    floor_t      target_floor;
    direction_t  target_direction;

    logic        flush_requests;
    logic        floor_arrive;

    request_registers i_request_registers (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .car_state           (car_state),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .flush_requests      (flush_requests),
        .up_requests         (up_requests),
        .down_requests       (down_requests),
        .panel_requests      (panel_requests),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    target_selector i_target_selector (
        .current_floor    (current_floor),
        .car_direction    (car_direction),
        .up_requests      (up_requests),
        .down_requests    (down_requests),
        .panel_requests   (panel_requests),
        .have_target      (have_target),
        .target_floor     (target_floor),
        .target_direction (target_direction)
    );

    car_fsm i_car_fsm (
        .clock            (clock),
        .reset_n          (reset_n),
        .power_switch     (power_switch),
        .emergency_btn    (emergency_btn),
        .door_open_btn    (door_open_btn),
        .door_close_btn   (door_close_btn),
        .have_target      (have_target),
        .target_floor     (target_floor),
        .target_direction (target_direction),
        .current_floor    (current_floor),
        .floor_arrive     (floor_arrive),
        .car_state        (car_state),
        .car_direction    (car_direction),
        .flush_requests   (flush_requests),
        .door_open_light  (door_open_light),
        .door_close_light (door_close_light)
    );

    car_position i_car_position (
        .clock         (clock),
        .reset_n       (reset_n),
        .car_state     (car_state),
        .current_floor (current_floor),
        .floor_arrive  (floor_arrive)
    );

endmodule

// ==== hdl/request_registers.sv ====
////////////////////
// Request registers
// Up, down and panel request bits with button lights,
// set on press, clear on stop, flush on park or emergency
////////////////////

`timescale 1ns/1ps

`include "elevator_consts.svh"

module request_registers import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  floor_t      current_floor,
    input  car_state_t  car_state,
    input  logic        power_switch,
    input  logic        emergency_btn,
    input  logic        flush_requests,
    output floor_mask_t up_requests,
    output floor_mask_t down_requests,
    output floor_mask_t panel_requests,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights
);

    floor_mask_t above_mask;
    floor_mask_t below_mask;
    floor_mask_t stop_clear;
    floor_mask_t call_set;
    floor_mask_t panel_set;

    // Which floors lie above and below the car
    always_comb begin
        for (int i = 0; i < `ELEV_NUM_FLOORS; i++) begin
            above_mask[i] = (floor_t'(i) > current_floor);
            below_mask[i] = (floor_t'(i) < current_floor);
        end
    end

    // Buttons are ignored while the power switch holds the car
    assign call_set  = power_switch ? '0 : floor_call_buttons;
    assign panel_set = power_switch ? '0 : panel_buttons;

    // A stopped car serves its own floor, and this beats a new press
    assign stop_clear = (car_state == CAR_STOPPED) ?
                        (floor_mask_t'(1) << current_floor) : '0;

    ////////////////////
    // Request and light registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            up_requests         <= '0;
            down_requests       <= '0;
            panel_requests      <= '0;
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (flush_requests || emergency_btn) begin
            up_requests         <= '0;
            down_requests       <= '0;
            panel_requests      <= '0;
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // Hall call class depends on where the car is now
            up_requests         <= (up_requests | (call_set & above_mask)) & ~stop_clear;
            down_requests       <= (down_requests | (call_set & below_mask)) & ~stop_clear;
            panel_requests      <= (panel_requests | panel_set) & ~stop_clear;
            call_button_lights  <= (call_button_lights | call_set) & ~stop_clear;
            panel_button_lights <= (panel_button_lights | panel_set) & ~stop_clear;
        end
    end

endmodule

// ==== hdl/target_selector.sv ====
////////////////////
// Target selector
// Priority scan over panel, up and down requests
// for the next target floor and its direction
////////////////////

`timescale 1ns/1ps

`include "elevator_consts.svh"

module target_selector import elevator_pkg::*; (
    input  floor_t      current_floor,
    input  direction_t  car_direction,
    input  floor_mask_t up_requests,
    input  floor_mask_t down_requests,
    input  floor_mask_t panel_requests,
    output logic        have_target,
    output floor_t      target_floor,
    output direction_t  target_direction
);

    // Top down scan so the nearest floor above the car is the last hit
    function automatic logic find_above(input floor_mask_t mask, input floor_t here,
                                        output floor_t idx);
        logic found;
        found = 1'b0;
        idx   = here;
        for (int i = `ELEV_NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i] && (floor_t'(i) > here)) begin
                found = 1'b1;
                idx   = floor_t'(i);
            end
        end
        return found;
    endfunction

    // Nearest set floor below the car
    function automatic logic find_below(input floor_mask_t mask, input floor_t here,
                                        output floor_t idx);
        logic found;
        found = 1'b0;
        idx   = here;
        for (int i = 0; i < `ELEV_NUM_FLOORS; i++) begin
            if (mask[i] && (floor_t'(i) < here)) begin
                found = 1'b1;
                idx   = floor_t'(i);
            end
        end
        return found;
    endfunction

    logic   pa_hit, pb_hit, ua_hit, ub_hit, da_hit, db_hit;
    floor_t pa_idx, pb_idx, ua_idx, ub_idx, da_idx, db_idx;

    always_comb begin
        pa_hit = find_above(panel_requests, current_floor, pa_idx);
        pb_hit = find_below(panel_requests, current_floor, pb_idx);
        ua_hit = find_above(up_requests, current_floor, ua_idx);
        ub_hit = find_below(up_requests, current_floor, ub_idx);
        da_hit = find_above(down_requests, current_floor, da_idx);
        db_hit = find_below(down_requests, current_floor, db_idx);

        have_target  = 1'b1;
        target_floor = current_floor;

        // Panel requests first with the own direction before the other one
        if ((car_direction == DIR_UP) && pa_hit)        target_floor = pa_idx;
        else if ((car_direction == DIR_DOWN) && pb_hit) target_floor = pb_idx;
        else if (pa_hit)                                target_floor = pa_idx;
        else if (pb_hit)                                target_floor = pb_idx;
        // Hall calls heading our way and lying ahead
        else if ((car_direction == DIR_UP) && ua_hit)   target_floor = ua_idx;
        else if ((car_direction == DIR_DOWN) && db_hit) target_floor = db_idx;
        // Whatever is left
        else if (ua_hit)                                target_floor = ua_idx;
        else if (ub_hit)                                target_floor = ub_idx;
        else if (db_hit)                                target_floor = db_idx;
        else if (da_hit)                                target_floor = da_idx;
        else                                            have_target  = 1'b0;

        if (!have_target) begin
            target_direction = car_direction;
        end else if (target_floor > current_floor) begin
            target_direction = DIR_UP;
        end else begin
            target_direction = DIR_DOWN;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the elevator testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_elevator \
    -f elevator_dispatch.f -Mdir obj_dir -o sim_elevator
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_elevator > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1

// ==== tests/tb_elevator.sv ====
////////////////////
// Elevator testbench
// Clock and reset, seeded random stimulus,
// request and priority model, checks
////////////////////

`timescale 1ns/1ps

`include "elevator_consts.svh"

module tb_elevator import elevator_pkg::*; ();

    localparam int N          = `ELEV_NUM_FLOORS;
    localparam int TIMEOUT    = 200;
    localparam int NUM_TRIALS = 8;

    logic        clock, reset_n;
    floor_mask_t floor_call_buttons, panel_buttons;
    logic        door_open_btn, door_close_btn, emergency_btn, power_switch;
    floor_t      current_floor;
    car_state_t  car_state;
    direction_t  car_direction;
    floor_mask_t call_button_lights, panel_button_lights;
    logic        door_open_light, door_close_light;

    integer seed;
    int     errors, checks, tests, err_mark;

    // Model of the request bits, the lights, the floor and the direction
    floor_mask_t m_up, m_down, m_panel, m_calls, m_lamps;
    int          m_floor;
    bit          m_dir_up;

    elevator_top i_elevator_top (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-12s %s", name, (errors == err_mark) ? "passed" : "FAILED");
        err_mark = errors;
    endtask

    task automatic await_moving();
        int n;
        n = 0;
        while (car_state != CAR_MOVING_UP && car_state != CAR_MOVING_DOWN && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        assert (car_state == CAR_MOVING_UP || car_state == CAR_MOVING_DOWN) else begin
            $display("ERROR: car did not leave floor %0d within %0d cycles", m_floor, TIMEOUT);
            errors++;
        end
    endtask

    task automatic await_state(input car_state_t want);
        int n;
        n = 0;
        while (car_state != want && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        assert (car_state == want) else begin
            $display("ERROR: car did not reach %s within %0d cycles", want.name(), TIMEOUT);
            errors++;
        end
    endtask

    // Random floor other than the one the car stands at
    function automatic int rand_floor();
        int f;
        f = $unsigned($random(seed)) % (N - 1);
        if (f >= m_floor) f++;
        return f;
    endfunction

    // Nearest set floor strictly above or below here or -1 if there is none
    function automatic int nearest(input floor_mask_t mask, input int here, input bit look_up);
        int f;
        nearest = -1;
        for (f = look_up ? here + 1 : here - 1; f >= 0 && f < N; f = look_up ? f + 1 : f - 1) begin
            if (mask[f] && nearest < 0) nearest = f;
        end
    endfunction

    function automatic int predict_next();
        int t;
        t = nearest(m_panel, m_floor, m_dir_up);
        if (t < 0) t = nearest(m_panel, m_floor, !m_dir_up);
        if (t < 0) t = m_dir_up ? nearest(m_up, m_floor, 1'b1) : nearest(m_down, m_floor, 1'b0);
        if (t < 0) t = nearest(m_up, m_floor, 1'b1);
        if (t < 0) t = nearest(m_up, m_floor, 1'b0);
        if (t < 0) t = nearest(m_down, m_floor, 1'b0);
        if (t < 0) t = nearest(m_down, m_floor, 1'b1);
        return t;
    endfunction

    function automatic void model_clear();
        m_up    = '0;
        m_down  = '0;
        m_panel = '0;
        m_calls = '0;
        m_lamps = '0;
    endfunction

    function automatic void model_stop(input int t);
        m_up[t]    = 1'b0;
        m_down[t]  = 1'b0;
        m_panel[t] = 1'b0;
        m_calls[t] = 1'b0;
        m_lamps[t] = 1'b0;
        m_floor    = t;
    endfunction

    // One cycle press driven from one falling edge to the next
    task automatic press(input floor_mask_t calls, input floor_mask_t panel);
        floor_call_buttons = calls;
        panel_buttons      = panel;
        for (int i = 0; i < N; i++) begin
            if (i != m_floor && calls[i]) begin
                m_calls[i] = 1'b1;
                if (i > m_floor) m_up[i] = 1'b1;
                else m_down[i] = 1'b1;
            end
            if (i != m_floor && panel[i]) begin
                m_panel[i] = 1'b1;
                m_lamps[i] = 1'b1;
            end
        end
        @(negedge clock);
        floor_call_buttons = '0;
        panel_buttons      = '0;
    endtask

    // Follow the car through every pending stop in model order
    task automatic serve_all();
        int t;
        t = predict_next();
        while (t >= 0) begin
            m_dir_up = (t > m_floor);
            await_moving();
            await_state(CAR_STOPPED);
            check_value("current_floor", current_floor, t);
            check_value("car_direction", car_direction, m_dir_up);
            model_stop(t);
            t = predict_next();
        end
        @(negedge clock);
        check_value("call_button_lights", call_button_lights, m_calls);
        check_value("panel_button_lights", panel_button_lights, m_lamps);
    endtask

    initial begin
        int k;
        int f0;
        int n;
        seed = 32'hc7f51af2;
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn = 1'b0;
        power_switch = 1'b0;
        model_clear();
        m_floor = 0;
        m_dir_up = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        ////////////////////
        // Reset and single trip
        ////////////////////
        @(negedge clock);
        check_value("current_floor", current_floor, 0);
        check_value("car_state", car_state, CAR_STOPPED);
        check_value("car_direction", car_direction, DIR_UP);
        check_value("call_button_lights", call_button_lights, 0);
        check_value("panel_button_lights", panel_button_lights, 0);
        check_value("door_open_light", door_open_light, 0);
        check_value("door_close_light", door_close_light, 0);
        end_test("reset");

        k = rand_floor();
        press('0, floor_mask_t'(1) << k);
        check_value("panel_button_lights", panel_button_lights, m_lamps);
        n = 0;
        while (!(car_state == CAR_STOPPED && current_floor == k) && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        f0 = (k > m_floor) ? k - m_floor : m_floor - k;
        check_value("travel cycles", n, f0 * `ELEV_TRAVEL_CYCLES + 2);
        m_dir_up = (k > m_floor);
        model_stop(k);
        @(negedge clock);
        check_value("panel_button_lights", panel_button_lights, 0);
        end_test("single_trip");

        // Random hall and panel sets served in priority order
        for (int trial = 0; trial < NUM_TRIALS; trial++) begin
            press(floor_mask_t'($random(seed) & $random(seed)),
                  floor_mask_t'($random(seed) & $random(seed) & $random(seed)));
            check_value("call_button_lights", call_button_lights, m_calls);
            check_value("panel_button_lights", panel_button_lights, m_lamps);
            check_value("up_requests", i_elevator_top.up_requests, m_up);
            check_value("down_requests", i_elevator_top.down_requests, m_down);
            serve_all();
        end
        end_test("priority");

        ////////////////////
        // Power switch, emergency, doors
        ////////////////////
        k = (m_floor <= 5) ? 10 : 0;
        m_dir_up = (k > m_floor);
        press(floor_mask_t'(1) << rand_floor(), floor_mask_t'(1) << k);
        await_moving();
        repeat (4) @(negedge clock);
        // Less than one leg travelled, so the car is still between m_floor and the next floor
        f0 = m_dir_up ? m_floor + 1 : m_floor - 1;
        power_switch = 1'b1;
        @(negedge clock);
        model_clear();
        check_value("call_button_lights", call_button_lights, 0);
        check_value("panel_button_lights", panel_button_lights, 0);
        await_state(CAR_PARKED);
        check_value("current_floor", current_floor, f0);
        press(floor_mask_t'($random(seed)), floor_mask_t'($random(seed)));
        @(negedge clock);
        model_clear();
        check_value("call_button_lights", call_button_lights, 0);
        check_value("panel_button_lights", panel_button_lights, 0);
        check_value("car_state", car_state, CAR_PARKED);
        power_switch = 1'b0;
        @(negedge clock);
        check_value("car_state", car_state, CAR_STOPPED);
        m_floor = f0;
        end_test("power_park");

        press('0, (floor_mask_t'(1) << rand_floor()) | (floor_mask_t'(1) << rand_floor()));
        check_value("panel_button_lights", panel_button_lights, m_lamps);
        emergency_btn = 1'b1;
        repeat (12) begin
            @(negedge clock);
            door_open_btn  = 1'($random(seed));
            door_close_btn = 1'($random(seed));
            #1;
            check_value("car_state", car_state, CAR_STOPPED);
            check_value("panel_button_lights", panel_button_lights, 0);
            check_value("door_open_light", door_open_light, 0);
            check_value("door_close_light", door_close_light, 0);
        end
        emergency_btn = 1'b0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        model_clear();
        @(negedge clock);
        check_value("car_state", car_state, CAR_STOPPED);
        check_value("current_floor", current_floor, m_floor);
        end_test("emergency");

        repeat (10) begin
            @(negedge clock);
            door_open_btn  = 1'($random(seed));
            door_close_btn = 1'($random(seed));
            #1;
            check_value("door_open_light", door_open_light, door_open_btn);
            check_value("door_close_light", door_close_light, door_close_btn);
        end
        @(negedge clock);
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        k = rand_floor();
        press('0, floor_mask_t'(1) << k);
        await_moving();
        repeat (6) begin
            @(negedge clock);
            door_open_btn  = 1'($random(seed));
            door_close_btn = 1'($random(seed));
            #1;
            check_value("door_open_light", door_open_light, 0);
            check_value("door_close_light", door_close_light, 0);
        end
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        await_state(CAR_STOPPED);
        check_value("current_floor", current_floor, k);
        model_stop(k);
        end_test("door_lights");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
